// File: hdl/ecc_pkg.sv
package ecc_pkg;

    localparam int unsigned ECC_DATA_W   = 40;
    localparam int unsigned ECC_PARITY_W = 7;
    localparam int unsigned ECC_CODE_W   = ECC_DATA_W + ECC_PARITY_W;
    localparam int unsigned NUM_BANKS    = 4;
    localparam int unsigned BANK_WORDS   = 16;

    typedef logic [ECC_DATA_W-1:0]         ecc_data_t;
    typedef logic [ECC_PARITY_W-1:0]       ecc_parity_t;
    typedef logic [ECC_CODE_W-1:0]         ecc_code_t;     // Parity above data.
    typedef logic [ECC_PARITY_W-1:0]       ecc_syndrome_t;
    typedef logic [$clog2(BANK_WORDS)-1:0] bank_index_t;
    typedef logic [$clog2(NUM_BANKS)-1:0]  bank_sel_t;
    typedef logic [15:0]                   err_count_t;
    typedef logic [7:0]                    apb_addr_t;
    typedef logic [31:0]                   apb_data_t;

    localparam apb_addr_t REG_WDATA_LO = 8'h00;
    localparam apb_addr_t REG_WDATA_HI = 8'h04;
    localparam apb_addr_t REG_ADDR     = 8'h08;
    localparam apb_addr_t REG_CMD      = 8'h0C;
    localparam apb_addr_t REG_INJECT   = 8'h10;
    localparam apb_addr_t REG_CTRL     = 8'h14;
    localparam apb_addr_t REG_RDATA_LO = 8'h18;
    localparam apb_addr_t REG_RDATA_HI = 8'h1C;
    localparam apb_addr_t REG_STATUS   = 8'h20;
    localparam apb_addr_t REG_SCOUNT   = 8'h24;
    localparam apb_addr_t REG_DCOUNT   = 8'h28;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_STORE = 2'd1,
        CMD_LOAD  = 2'd2
    } cmd_e;

    typedef struct packed {
        logic        store;
        logic        load;
        bank_sel_t   bank;
        bank_index_t index;
        ecc_data_t   data;
        ecc_code_t   flip;
        logic        bypass;
    } bank_req_t;

    typedef struct packed {
        logic      valid;
        ecc_data_t data;
        logic      sbit;
        logic      dbit;
    } bank_rsp_t;

    // H-matrix columns of the data bits, index 0 first; all odd weight.
    localparam ecc_syndrome_t ECC_H_COLS [ECC_DATA_W] = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111, 7'b1001001,
        7'b1001010, 7'b0001011, 7'b1001100, 7'b0001101, 7'b0001110,
        7'b1001111, 7'b1010001, 7'b1010010, 7'b0010011, 7'b1010100,
        7'b0010101, 7'b0010110, 7'b1010111, 7'b1011000, 7'b0011001,
        7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101, 7'b1011110,
        7'b0011111, 7'b1100001, 7'b1100010, 7'b0100011, 7'b1100100,
        7'b0100101, 7'b0100110, 7'b1100111, 7'b1101000, 7'b0101001,
        7'b0101010, 7'b1101011, 7'b0101100, 7'b1101101, 7'b1101110
    };

endpackage

// File: hdl/ecc_40_codec.sv
module ecc_40_codec (
    input  ecc_pkg::ecc_data_t   data,
    input  ecc_pkg::ecc_parity_t parity,
    input  logic                 bypass,
    output ecc_pkg::ecc_parity_t parity_gen,
    output ecc_pkg::ecc_data_t   data_corr,
    output logic                 sbit_err,
    output logic                 dbit_err
);

    import ecc_pkg::*;

    ecc_syndrome_t syndrome;
    ecc_data_t     mask;
    logic          col_hit;
    logic          par_hit;
    logic          single;

    // Each set data bit toggles the check bits of its column.
    always_comb begin
        parity_gen = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (data[i]) begin
                parity_gen = parity_gen ^ ECC_H_COLS[i];
            end
        end
    end

    assign syndrome = parity ^ parity_gen;

    // One-hot correction mask from the matching column.
    always_comb begin
        mask    = '0;
        col_hit = 1'b0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (syndrome == ECC_H_COLS[i]) begin
                mask[i] = 1'b1;
                col_hit = 1'b1;
            end
        end
    end

    // Exactly one syndrome bit set means a parity bit flipped.
    assign par_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);
    assign single  = col_hit || par_hit;

    assign data_corr = bypass ? data : (data ^ mask);
    assign sbit_err  = !bypass && single;
    assign dbit_err  = !bypass && (syndrome != '0) && !single;  // Uncorrectable.

endmodule

// File: hdl/ecc_bank.sv
module ecc_bank #(
    parameter int unsigned BANK_ID = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  ecc_pkg::bank_req_t req,
    output ecc_pkg::bank_rsp_t rsp
);

    import ecc_pkg::*;

    ecc_code_t   mem [BANK_WORDS];
    ecc_parity_t enc_parity;
    ecc_code_t   code_q;
    logic        bypass_q;
    logic        valid_q;
    logic        hit;
    ecc_data_t   dec_data;
    logic        dec_sbit;
    logic        dec_dbit;

    assign hit = (req.bank == bank_sel_t'(BANK_ID));

    ecc_40_codec u_encoder (
        .data       (req.data),
        .parity     ('0),
        .bypass     (1'b1),
        .parity_gen (enc_parity),
        .data_corr  (),
        .sbit_err   (),
        .dbit_err   ()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BANK_WORDS; i++) begin
                mem[i] <= '0;  // Zero is a valid codeword.
            end
            code_q   <= '0;
            bypass_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= req.load && hit;
            if (req.store && hit) begin
                mem[req.index] <= {enc_parity, req.data} ^ req.flip;
            end
            if (req.load && hit) begin
                code_q   <= mem[req.index];
                bypass_q <= req.bypass;
            end
        end
    end

    ecc_40_codec u_decoder (
        .data       (code_q[ECC_DATA_W-1:0]),
        .parity     (code_q[ECC_CODE_W-1:ECC_DATA_W]),
        .bypass     (bypass_q),
        .parity_gen (),
        .data_corr  (dec_data),
        .sbit_err   (dec_sbit),
        .dbit_err   (dec_dbit)
    );

    assign rsp.valid = valid_q;
    assign rsp.data  = dec_data;
    assign rsp.sbit  = dec_sbit;
    assign rsp.dbit  = dec_dbit;

endmodule

// File: hdl/ecc_apb_front.sv
module ecc_apb_front (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  ecc_pkg::apb_addr_t   paddr,
    input  ecc_pkg::apb_data_t   pwdata,
    output ecc_pkg::apb_data_t   prdata,
    output logic                 pready,
    output logic                 pslverr,
    output ecc_pkg::bank_req_t   req,
    input  ecc_pkg::ecc_data_t   rd_data,
    input  logic                 status_sbit,
    input  logic                 status_dbit,
    input  ecc_pkg::err_count_t  scount,
    input  ecc_pkg::err_count_t  dcount
);

    import ecc_pkg::*;

    ecc_data_t   wdata;
    bank_sel_t   bank_q;
    bank_index_t index_q;
    logic [5:0]  inj_pos_a;
    logic        inj_en_a;
    logic [5:0]  inj_pos_b;
    logic        inj_en_b;
    logic        bypass;
    logic        access;
    logic        wr_en;
    logic        addr_ok;
    logic        read_only;
    cmd_e        cmd;
    ecc_code_t   flip;

    assign access = psel && penable;
    assign wr_en  = access && pwrite && !pslverr;
    assign pready = 1'b1;

    always_comb begin
        prdata    = '0;
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (paddr)
            REG_WDATA_LO: prdata = wdata[31:0];
            REG_WDATA_HI: prdata = apb_data_t'(wdata[ECC_DATA_W-1:32]);
            REG_ADDR:     prdata = apb_data_t'({bank_q, index_q});
            REG_CMD:      prdata = '0;  // Write only.
            REG_INJECT:   prdata = apb_data_t'({inj_en_b, inj_pos_b, 1'b0, inj_en_a, inj_pos_a});
            REG_CTRL:     prdata = apb_data_t'(bypass);
            REG_RDATA_LO: begin
                prdata    = rd_data[31:0];
                read_only = 1'b1;
            end
            REG_RDATA_HI: begin
                prdata    = apb_data_t'(rd_data[ECC_DATA_W-1:32]);
                read_only = 1'b1;
            end
            REG_STATUS: begin
                prdata    = apb_data_t'({status_dbit, status_sbit});
                read_only = 1'b1;
            end
            REG_SCOUNT: begin
                prdata    = apb_data_t'(scount);
                read_only = 1'b1;
            end
            REG_DCOUNT: begin
                prdata    = apb_data_t'(dcount);
                read_only = 1'b1;
            end
            default: addr_ok = 1'b0;
        endcase
    end

    assign pslverr = access && (!addr_ok || (pwrite && read_only));

    always_comb begin
        cmd = CMD_NONE;
        if (wr_en && paddr == REG_CMD) begin
            if (pwdata == apb_data_t'(CMD_STORE)) begin
                cmd = CMD_STORE;
            end else if (pwdata == apb_data_t'(CMD_LOAD)) begin
                cmd = CMD_LOAD;
            end
        end
    end

    // Positions past bit 46 shift out and flip nothing.
    assign flip = (inj_en_a ? (ecc_code_t'(1) << inj_pos_a) : '0)
                | (inj_en_b ? (ecc_code_t'(1) << inj_pos_b) : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wdata     <= '0;
            bank_q    <= '0;
            index_q   <= '0;
            inj_pos_a <= '0;
            inj_en_a  <= 1'b0;
            inj_pos_b <= '0;
            inj_en_b  <= 1'b0;
            bypass    <= 1'b0;
            req       <= '0;
        end else begin
            req.store <= 1'b0;
            req.load  <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    REG_WDATA_LO: wdata[31:0] <= pwdata;
                    REG_WDATA_HI: wdata[ECC_DATA_W-1:32] <= pwdata[7:0];
                    REG_ADDR: begin
                        index_q <= pwdata[3:0];
                        bank_q  <= pwdata[5:4];
                    end
                    REG_INJECT: begin
                        inj_pos_a <= pwdata[5:0];
                        inj_en_a  <= pwdata[6];
                        inj_pos_b <= pwdata[13:8];
                        inj_en_b  <= pwdata[14];
                    end
                    REG_CTRL: bypass <= pwdata[0];
                    default: ;
                endcase
            end
            if (cmd != CMD_NONE) begin
                req.store  <= (cmd == CMD_STORE);
                req.load   <= (cmd == CMD_LOAD);
                req.bank   <= bank_q;
                req.index  <= index_q;
                req.data   <= wdata;
                req.flip   <= (cmd == CMD_STORE) ? flip : '0;
                req.bypass <= bypass;
            end
            if (cmd == CMD_STORE) begin
                inj_en_a <= 1'b0;  // One-shot.
                inj_en_b <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/ecc_status_merge.sv
module ecc_status_merge (
    input  logic                clk,
    input  logic                reset,
    input  ecc_pkg::bank_rsp_t  rsp [ecc_pkg::NUM_BANKS],
    output ecc_pkg::ecc_data_t  rd_data,
    output logic                status_sbit,
    output logic                status_dbit,
    output ecc_pkg::err_count_t scount,
    output ecc_pkg::err_count_t dcount
);

    import ecc_pkg::*;

    bank_rsp_t sel;

    // At most one bank answers per cycle.
    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (rsp[i].valid) begin
                sel = rsp[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data     <= '0;
            status_sbit <= 1'b0;
            status_dbit <= 1'b0;
            scount      <= '0;
            dcount      <= '0;
        end else if (sel.valid) begin
            rd_data     <= sel.data;
            status_sbit <= sel.sbit;
            status_dbit <= sel.dbit;
            if (sel.sbit && scount != '1) begin
                scount <= scount + 1'b1;  // Saturates.
            end
            if (sel.dbit && dcount != '1) begin
                dcount <= dcount + 1'b1;
            end
        end
    end

endmodule

// File: hdl/ecc_mem_top.sv
module ecc_mem_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  ecc_pkg::apb_addr_t paddr,
    input  ecc_pkg::apb_data_t pwdata,
    output ecc_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr
);

    import ecc_pkg::*;

    bank_req_t  req;
    bank_rsp_t  rsp [NUM_BANKS];
    ecc_data_t  rd_data;
    logic       status_sbit;
    logic       status_dbit;
    err_count_t scount;
    err_count_t dcount;

    ecc_apb_front u_front (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .req         (req),
        .rd_data     (rd_data),
        .status_sbit (status_sbit),
        .status_dbit (status_dbit),
        .scount      (scount),
        .dcount      (dcount)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        ecc_bank #(
            .BANK_ID (g)
        ) u_bank (
            .clk   (clk),
            .reset (reset),
            .req   (req),
            .rsp   (rsp[g])
        );
    end

    ecc_status_merge u_merge (
        .clk         (clk),
        .reset       (reset),
        .rsp         (rsp),
        .rd_data     (rd_data),
        .status_sbit (status_sbit),
        .status_dbit (status_dbit),
        .scount      (scount),
        .dcount      (dcount)
    );

endmodule

// File: sim/ecc_mem_props.sv
module ecc_mem_props (
    input logic               clk,
    input logic               reset,
    input logic               psel,
    input logic               penable,
    input logic               pready,
    input ecc_pkg::bank_rsp_t rsp [ecc_pkg::NUM_BANKS],
    input logic               status_sbit,
    input logic               status_dbit
);

    import ecc_pkg::*;

    int unsigned          fail_count = 0;
    logic [NUM_BANKS-1:0] valid_bits;
    logic                 both_flags;

    always_comb begin
        valid_bits = '0;
        both_flags = status_sbit && status_dbit;
        for (int i = 0; i < NUM_BANKS; i++) begin
            valid_bits[i] = rsp[i].valid;
            both_flags    = both_flags || (rsp[i].valid && rsp[i].sbit && rsp[i].dbit);
        end
    end

    // Access phase must follow a setup cycle.
    penable_after_setup: assert property (@(posedge clk) disable iff (reset)
        (penable && !$past(penable)) |-> (psel && $past(psel)))
    else begin
        $error("penable rose without a psel setup cycle");
        fail_count++;
    end

    pready_high: assert property (@(posedge clk) disable iff (reset) pready)
    else begin
        $error("pready dropped low");
        fail_count++;
    end

    flags_exclusive: assert property (@(posedge clk) disable iff (reset) !both_flags)
    else begin
        $error("single and double error flags both high");
        fail_count++;
    end

    one_bank_valid: assert property (@(posedge clk) disable iff (reset) $onehot0(valid_bits))
    else begin
        $error("more than one bank response valid");
        fail_count++;
    end

endmodule

// File: sim/ecc_mem_checker.sv
module ecc_mem_checker (
    input  logic               clk,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  ecc_pkg::apb_addr_t paddr,
    input  ecc_pkg::apb_data_t prdata,
    input  logic               pslverr,
    input  logic               exp_en,
    input  logic               exp_chk_data,
    input  ecc_pkg::apb_data_t exp_data,
    input  logic               exp_err,
    input  int unsigned        test_id,
    input  logic               test_done,
    output int unsigned        check_count,
    output int unsigned        error_count,
    output int unsigned        tests_failed
);

    int unsigned test_errors;

    // Sampled mid-cycle, where the access phase is stable.
    initial begin
        check_count  = 0;
        error_count  = 0;
        tests_failed = 0;
        test_errors  = 0;
        forever begin
            @(negedge clk);
            if (psel && penable && exp_en) begin
                check_count++;
                if (pslverr !== exp_err) begin
                    $display("** Error @%0t: test %0d offset 0x%02h pslverr expected %b got %b",
                             $time, test_id, paddr, exp_err, pslverr);
                    error_count++;
                    test_errors++;
                end
                if (!pwrite && exp_chk_data && prdata !== exp_data) begin
                    $display("** Error @%0t: test %0d offset 0x%02h expected 0x%08h got 0x%08h",
                             $time, test_id, paddr, exp_data, prdata);
                    error_count++;
                    test_errors++;
                end
            end
            if (test_done) begin
                if (test_errors == 0) begin
                    $display("test %0d: ok", test_id);
                end else begin
                    $display("test %0d: %0d mismatches", test_id, test_errors);
                    tests_failed++;
                end
                test_errors = 0;
            end
        end
    end

endmodule

// File: sim/tb_ecc_mem.sv
module tb_ecc_mem;

    import ecc_pkg::*;

    typedef struct packed {
        bank_sel_t   bank;
        bank_index_t index;
        ecc_data_t   data;
        logic        en_a;
        logic [5:0]  pos_a;
        logic        en_b;
        logic [5:0]  pos_b;
        logic        bypass;
        logic        keep_inject;  // Store without rewriting INJECT.
    } test_row_t;

    localparam int NUM_ROWS       = 13;
    localparam int NUM_RELOADS    = 4;
    localparam int NUM_TESTS      = NUM_ROWS + NUM_RELOADS + 1;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 30 + 100;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        exp_en;
    logic        exp_chk_data;
    apb_data_t   exp_data;
    logic        exp_err;
    int unsigned test_id;
    logic        test_done;
    int unsigned check_count;
    int unsigned error_count;
    int unsigned tests_failed;
    int unsigned cycle_count;
    int unsigned xfer_count;
    test_row_t   rows [NUM_ROWS];
    logic [31:0] lcg_state;
    err_count_t  exp_scount;
    err_count_t  exp_dcount;

    ecc_mem_top u_ecc_mem_top (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    ecc_mem_checker u_checker (
        .clk          (clk),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .exp_en       (exp_en),
        .exp_chk_data (exp_chk_data),
        .exp_data     (exp_data),
        .exp_err      (exp_err),
        .test_id      (test_id),
        .test_done    (test_done),
        .check_count  (check_count),
        .error_count  (error_count),
        .tests_failed (tests_failed)
    );

    bind ecc_mem_top ecc_mem_props u_props (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pready      (pready),
        .rsp         (rsp),
        .status_sbit (status_sbit),
        .status_dbit (status_dbit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input int n, input bank_sel_t bank, input bank_index_t index,
                           input logic en_a, input logic [5:0] pos_a, input logic en_b,
                           input logic [5:0] pos_b, input logic bypass, input logic keep);
        logic [31:0] lo;
        lcg_state = lcg_next(lcg_state);
        lo        = lcg_state;
        lcg_state = lcg_next(lcg_state);
        rows[n]   = '{bank, index, {lcg_state[31:24], lo}, en_a, pos_a, en_b, pos_b, bypass, keep};
    endtask

    task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            input logic chk_data, input apb_data_t exp_rdata,
                            input logic exp_slverr);
        psel         = 1'b1;
        penable      = 1'b0;
        pwrite       = write;
        paddr        = addr;
        pwdata       = wdata;
        exp_en       = 1'b1;
        exp_chk_data = chk_data;
        exp_data     = exp_rdata;
        exp_err      = exp_slverr;
        xfer_count++;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        exp_en  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_xfer(1'b1, addr, wdata, 1'b0, '0, 1'b0);
    endtask

    task automatic apb_read_check(input apb_addr_t addr, input apb_data_t exp_rdata);
        apb_xfer(1'b0, addr, '0, 1'b1, exp_rdata, 1'b0);
    endtask

    task automatic load_and_check(input ecc_data_t exp_d, input logic exp_s, input logic exp_dd);
        apb_write(REG_CMD, 32'd2);
        @(posedge clk);  // Merge latches two edges after the command.
        #1;
        exp_scount = exp_scount + exp_s;
        exp_dcount = exp_dcount + exp_dd;
        apb_read_check(REG_RDATA_LO, exp_d[31:0]);
        apb_read_check(REG_RDATA_HI, apb_data_t'(exp_d[ECC_DATA_W-1:32]));
        apb_read_check(REG_STATUS, apb_data_t'({exp_dd, exp_s}));
        apb_read_check(REG_SCOUNT, apb_data_t'(exp_scount));
        apb_read_check(REG_DCOUNT, apb_data_t'(exp_dcount));
    endtask

    task automatic finish_test();
        test_done = 1'b1;
        @(posedge clk);
        #1;
        test_done = 1'b0;
    endtask

    task automatic run_row(input int n);
        test_row_t row;
        ecc_code_t flips;
        ecc_data_t exp_d;
        logic      exp_s;
        logic      exp_dd;
        row   = rows[n];
        flips = '0;
        if (!row.keep_inject && row.en_a) flips[row.pos_a] = 1'b1;
        if (!row.keep_inject && row.en_b) flips[row.pos_b] = 1'b1;
        exp_d  = row.data;
        exp_s  = 1'b0;
        exp_dd = 1'b0;
        if (row.bypass) begin
            exp_d = row.data ^ flips[ECC_DATA_W-1:0];
        end else if ($countones(flips) == 1) begin
            exp_s = 1'b1;
        end else if ($countones(flips) > 1) begin
            exp_d  = row.data ^ flips[ECC_DATA_W-1:0];  // Left uncorrected.
            exp_dd = 1'b1;
        end
        test_id = n;
        apb_write(REG_WDATA_LO, row.data[31:0]);
        apb_write(REG_WDATA_HI, apb_data_t'(row.data[ECC_DATA_W-1:32]));
        apb_write(REG_ADDR, apb_data_t'({row.bank, row.index}));
        if (!row.keep_inject) begin
            apb_write(REG_INJECT, apb_data_t'({row.en_b, row.pos_b, 1'b0, row.en_a, row.pos_a}));
        end
        apb_write(REG_CTRL, apb_data_t'(row.bypass));
        apb_write(REG_CMD, 32'd1);
        load_and_check(exp_d, exp_s, exp_dd);
        finish_test();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        exp_en       = 1'b0;
        exp_chk_data = 1'b0;
        exp_data     = '0;
        exp_err      = 1'b0;
        test_id      = 0;
        test_done    = 1'b0;
        xfer_count   = 0;
        exp_scount   = '0;
        exp_dcount   = '0;
        lcg_state    = 32'd75576;

        // Bank, index, inject A, inject B, bypass, keep.
        add_row(0, 2'd0, 4'd0, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(1, 2'd1, 4'd3, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(2, 2'd2, 4'd7, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(3, 2'd3, 4'd15, 1'b0, 6'd0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(4, 2'd0, 4'd5, 1'b1, 6'd3, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(5, 2'd1, 4'd9, 1'b0, 6'd0, 1'b1, 6'd44, 1'b0, 1'b0);  // Parity bit.
        add_row(6, 2'd2, 4'd2, 1'b1, 6'd39, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(7, 2'd3, 4'd4, 1'b1, 6'd0, 1'b1, 6'd21, 1'b0, 1'b0);
        add_row(8, 2'd0, 4'd11, 1'b1, 6'd12, 1'b1, 6'd40, 1'b0, 1'b0);
        add_row(9, 2'd1, 4'd12, 1'b1, 6'd7, 1'b1, 6'd30, 1'b1, 1'b0);
        add_row(10, 2'd2, 4'd13, 1'b1, 6'd46, 1'b1, 6'd35, 1'b1, 1'b0);
        add_row(11, 2'd2, 4'd14, 1'b1, 6'd18, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(12, 2'd3, 4'd14, 1'b1, 6'd18, 1'b0, 6'd0, 1'b0, 1'b1);

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end

        // Early words must survive the later traffic.
        for (int i = 0; i < NUM_RELOADS; i++) begin
            test_id = NUM_ROWS + i;
            apb_write(REG_ADDR, apb_data_t'({rows[i].bank, rows[i].index}));
            apb_write(REG_CTRL, 32'd0);
            load_and_check(rows[i].data, 1'b0, 1'b0);
            finish_test();
        end

        test_id = NUM_ROWS + NUM_RELOADS;
        apb_write(REG_WDATA_LO, 32'hA5C3_0F96);
        apb_xfer(1'b0, 8'h2C, '0, 1'b0, '0, 1'b1);
        apb_xfer(1'b1, REG_STATUS, 32'h3, 1'b0, '0, 1'b1);
        apb_xfer(1'b1, 8'h30, 32'hFFFF_FFFF, 1'b0, '0, 1'b1);
        apb_read_check(REG_STATUS, 32'h0);
        apb_read_check(REG_WDATA_LO, 32'hA5C3_0F96);
        apb_read_check(REG_SCOUNT, apb_data_t'(exp_scount));
        finish_test();

        @(posedge clk);
        #1;
        if (check_count != xfer_count) begin
            $display("Checker compared %0d transfers but %0d were driven",
                     check_count, xfer_count);
        end
        $display("Tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
                 NUM_TESTS, tests_failed, check_count, error_count,
                 u_ecc_mem_top.u_props.fail_count);
        if (error_count == 0 && tests_failed == 0 && check_count == xfer_count &&
                u_ecc_mem_top.u_props.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/ecc_pkg.sv
hdl/ecc_40_codec.sv
hdl/ecc_bank.sv
hdl/ecc_apb_front.sv
hdl/ecc_status_merge.sv
hdl/ecc_mem_top.sv
sim/ecc_mem_props.sv
sim/ecc_mem_checker.sv
sim/tb_ecc_mem.sv

// File: Bender.yml
package:
  name: ecc_mem

sources:
  - hdl/ecc_pkg.sv
  - hdl/ecc_40_codec.sv
  - hdl/ecc_bank.sv
  - hdl/ecc_apb_front.sv
  - hdl/ecc_status_merge.sv
  - hdl/ecc_mem_top.sv
  - target: simulation
    files:
      - sim/ecc_mem_props.sv
      - sim/ecc_mem_checker.sv
      - sim/tb_ecc_mem.sv
